//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_rename_unit
FILELIST  := verilog.f
BUILD_DIR := obj_dir
LOG       := sim.log

SOURCES := $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^RESULT: PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- free_list.sv
// Free list of physical registers as a circular queue.
// Requests are strobes with no back-pressure. The caller keeps allocations
// within the free count, which the assertions below check.
// On recover the head reloads a saved value while the tail is kept,
// so registers retired since the checkpoint stay free.

`timescale 1ns/1ps

module free_list #(
  parameter int RENAME_WIDTH = 2
) (
  input                                             clock,
  input                                             reset,
  input        [RENAME_WIDTH-1:0]                   alloc_req,
  output rename_pkg::phys_idx_t [RENAME_WIDTH-1:0]  alloc_prd,
  input        [RENAME_WIDTH-1:0]                   retire_valid,
  input  rename_pkg::phys_idx_t [RENAME_WIDTH-1:0]  retire_prd,
  input                                             recover,
  input  rename_pkg::fl_ptr_t                       head_saved,
  output rename_pkg::fl_ptr_t                       head,
  output logic                                      allocatable
);

  import rename_pkg::*;

  phys_idx_t queue [PRF_SIZE];
  fl_ptr_t   tail;
  fl_ptr_t   free_count;
  fl_ptr_t   alloc_count;
  fl_ptr_t   retire_count;
  phys_idx_t retire_slot [RENAME_WIDTH];

  ////////////////////////////////////////////////////////////////////////////
  // Allocation and retire slots, taken in slot order
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    fl_ptr_t offset;
    offset = '0;
    for (int k = 0; k < RENAME_WIDTH; k++) begin
      // Idle slots see the next entry but consume nothing
      alloc_prd[k] = queue[phys_idx_t'(head + offset)];
      if (alloc_req[k]) begin
        offset = offset + 1'b1;
      end
    end
    alloc_count = offset;
  end

  always_comb begin
    fl_ptr_t offset;
    offset = '0;
    for (int k = 0; k < RENAME_WIDTH; k++) begin
      retire_slot[k] = phys_idx_t'(tail + offset);
      if (retire_valid[k]) begin
        offset = offset + 1'b1;
      end
    end
    retire_count = offset;
  end

  assign free_count  = tail - head;
  assign allocatable = (free_count >= fl_ptr_t'(RENAME_WIDTH));

  // Queue starts out holding ARF_SIZE .. PRF_SIZE-1 in order
  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < PRF_SIZE; i++) begin
        queue[i] <= phys_idx_t'(i + ARF_SIZE);
      end
    end else begin
      for (int k = 0; k < RENAME_WIDTH; k++) begin
        if (retire_valid[k]) begin
          queue[retire_slot[k]] <= retire_prd[k];
        end
      end
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      head <= '0;
      tail <= fl_ptr_t'(FREE_AT_RESET);
    end else begin
      head <= recover ? head_saved : head + alloc_count;
      tail <= tail + retire_count;
    end
  end

  no_over_alloc: assert property (
    @(posedge clock) disable iff (reset) alloc_count <= free_count
  ) else $error("free_list: %0d allocations with %0d free", alloc_count, free_count);

  no_retire_overflow: assert property (
    @(posedge clock) disable iff (reset)
    (int'(free_count) + int'(retire_count)) <= PRF_SIZE
  ) else $error("free_list: retire overflows the queue");

endmodule

//--- map_table.sv
// Architectural to physical register map for up to RENAME_WIDTH renames.
// Slots are resolved in order, so a later slot sees the destinations of
// earlier slots in the same cycle. All rename outputs are combinational.
// A recover in the same cycle discards the renames and loads map_saved.
// After reset the map is the identity, so prev_prd always holds a real name.

`timescale 1ns/1ps

module map_table #(
  parameter int RENAME_WIDTH = 2
) (
  input                                             clock,
  input                                             reset,
  input        [RENAME_WIDTH-1:0]                   rename_valid,
  input  rename_pkg::arch_idx_t [RENAME_WIDTH-1:0]  rs1,
  input  rename_pkg::arch_idx_t [RENAME_WIDTH-1:0]  rs2,
  input  rename_pkg::arch_idx_t [RENAME_WIDTH-1:0]  rd,
  input  rename_pkg::phys_idx_t [RENAME_WIDTH-1:0]  alloc_prd,
  input                                             allocatable,
  output rename_pkg::phys_idx_t [RENAME_WIDTH-1:0]  prs1,
  output rename_pkg::phys_idx_t [RENAME_WIDTH-1:0]  prs2,
  output rename_pkg::phys_idx_t [RENAME_WIDTH-1:0]  prd,
  output rename_pkg::phys_idx_t [RENAME_WIDTH-1:0]  prev_prd,
  output logic [RENAME_WIDTH-1:0]                   alloc_req,
  input                                             recover,
  input  rename_pkg::map_snapshot_t                 map_saved,
  output rename_pkg::map_snapshot_t                 map_state
);

  import rename_pkg::*;

  map_snapshot_t map_q;
  map_snapshot_t map_next;

  ////////////////////////////////////////////////////////////////////////////
  // Group rename over a working copy of the map
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    map_next = map_q;
    for (int k = 0; k < RENAME_WIDTH; k++) begin
      // Sources and old mapping read before this slot writes
      prs1[k]     = map_next[rs1[k]];
      prs2[k]     = map_next[rs2[k]];
      prev_prd[k] = map_next[rd[k]];
      prd[k]      = alloc_prd[k];
      if (rename_valid[k]) begin
        map_next[rd[k]] = alloc_prd[k];
      end
    end
  end

  // A recover cancels the group, so nothing is taken from the free list
  assign alloc_req = rename_valid & {RENAME_WIDTH{~recover}};

  assign map_state = map_q;

  ////////////////////////////////////////////////////////////////////////////
  // Registered map
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < ARF_SIZE; i++) begin
        map_q[i] <= phys_idx_t'(i);
      end
    end else if (recover) begin
      map_q <= map_saved;
    end else begin
      map_q <= map_next;
    end
  end

  // Free list reports too few entries for a full group
  no_rename_when_full: assert property (
    @(posedge clock) disable iff (reset) (|rename_valid) |-> allocatable
  ) else $error("map_table: rename while allocatable is low");

endmodule

//--- rename_pkg.sv
// Sizes and index types shared by the rename stage.
// Integer registers only. There is no hard-wired zero register.
// After reset architectural register i maps to physical register i,
// so the first FREE_AT_RESET physical registers above ARF_SIZE are free.

package rename_pkg;

  localparam int ARF_SIZE = 32;
  localparam int PRF_SIZE = 64;

  // Free registers left once the identity map is in place
  localparam int FREE_AT_RESET = PRF_SIZE - ARF_SIZE;

  typedef logic [$clog2(ARF_SIZE)-1:0] arch_idx_t;
  typedef logic [$clog2(PRF_SIZE)-1:0] phys_idx_t;

  // One extra bit so that a full queue differs from an empty one
  typedef logic [$clog2(PRF_SIZE):0] fl_ptr_t;

  // Whole map table, entry i holds the physical name of x[i]
  typedef phys_idx_t [ARF_SIZE-1:0] map_snapshot_t;

endpackage

//--- rename_unit.sv
// Register rename stage for an out-of-order integer core.
// Each cycle renames up to RENAME_WIDTH instructions, takes checkpoints of
// the map and the free-list head, and recovers both in one cycle.
// Requests are one-cycle strobes with no acknowledge. Do not rename while
// allocatable is low. The caller picks every checkpoint index.

`timescale 1ns/1ps

module rename_unit #(
  parameter int RENAME_WIDTH = 2,
  parameter int CHECKPOINTS = 4,
  localparam int CP_IDX_W = (CHECKPOINTS > 1) ? $clog2(CHECKPOINTS) : 1
) (
  input                                             clock,
  input                                             reset,
  input        [RENAME_WIDTH-1:0]                   rename_valid,
  input  rename_pkg::arch_idx_t [RENAME_WIDTH-1:0]  rs1,
  input  rename_pkg::arch_idx_t [RENAME_WIDTH-1:0]  rs2,
  input  rename_pkg::arch_idx_t [RENAME_WIDTH-1:0]  rd,
  output rename_pkg::phys_idx_t [RENAME_WIDTH-1:0]  prs1,
  output rename_pkg::phys_idx_t [RENAME_WIDTH-1:0]  prs2,
  output rename_pkg::phys_idx_t [RENAME_WIDTH-1:0]  prd,
  output rename_pkg::phys_idx_t [RENAME_WIDTH-1:0]  prev_prd,
  output logic                                      allocatable,
  input                                             check,
  input        [CP_IDX_W-1:0]                       check_idx,
  input                                             recover,
  input        [CP_IDX_W-1:0]                       recover_idx,
  input        [RENAME_WIDTH-1:0]                   retire_valid,
  input  rename_pkg::phys_idx_t [RENAME_WIDTH-1:0]  retire_prd
);

  import rename_pkg::*;

  phys_idx_t [RENAME_WIDTH-1:0] alloc_prd;
  logic      [RENAME_WIDTH-1:0] alloc_req;
  map_snapshot_t                map_state;
  map_snapshot_t                map_saved;
  fl_ptr_t                      head;
  fl_ptr_t                      head_saved;

  free_list #(
    .RENAME_WIDTH (RENAME_WIDTH)
  ) u_free_list (
    .clock        (clock),
    .reset        (reset),
    .alloc_req    (alloc_req),
    .alloc_prd    (alloc_prd),
    .retire_valid (retire_valid),
    .retire_prd   (retire_prd),
    .recover      (recover),
    .head_saved   (head_saved),
    .head         (head),
    .allocatable  (allocatable)
  );

  // Map snapshots
  snapshot_store #(
    .CHECKPOINTS (CHECKPOINTS),
    .payload_t   (map_snapshot_t)
  ) map_checkpoints (
    .clock       (clock),
    .check       (check),
    .check_idx   (check_idx),
    .state_in    (map_state),
    .recover_idx (recover_idx),
    .state_out   (map_saved)
  );

  // Free-list head snapshots
  snapshot_store #(
    .CHECKPOINTS (CHECKPOINTS),
    .payload_t   (fl_ptr_t)
  ) head_checkpoints (
    .clock       (clock),
    .check       (check),
    .check_idx   (check_idx),
    .state_in    (head),
    .recover_idx (recover_idx),
    .state_out   (head_saved)
  );

  map_table #(
    .RENAME_WIDTH (RENAME_WIDTH)
  ) u_map_table (
    .clock        (clock),
    .reset        (reset),
    .rename_valid (rename_valid),
    .rs1          (rs1),
    .rs2          (rs2),
    .rd           (rd),
    .alloc_prd    (alloc_prd),
    .allocatable  (allocatable),
    .prs1         (prs1),
    .prs2         (prs2),
    .prd          (prd),
    .prev_prd     (prev_prd),
    .alloc_req    (alloc_req),
    .recover      (recover),
    .map_saved    (map_saved),
    .map_state    (map_state)
  );

endmodule

//--- snapshot_store.sv
// Checkpoint storage for one piece of rename state.
// The stored payload is chosen by the payload_t type parameter.
// Entries have no reset, so an index must be written before a recover reads it.
// The read port is combinational.

`timescale 1ns/1ps

module snapshot_store #(
  parameter int CHECKPOINTS = 4,
  parameter type payload_t = logic,
  localparam int CP_IDX_W = (CHECKPOINTS > 1) ? $clog2(CHECKPOINTS) : 1
) (
  input                 clock,
  input                 check,
  input  [CP_IDX_W-1:0] check_idx,
  input  payload_t      state_in,
  input  [CP_IDX_W-1:0] recover_idx,
  output payload_t      state_out
);

  payload_t entries [CHECKPOINTS];

  ////////////////////////////////////////////////////////////////////////////
  // Write on check, read at recover_idx in the same cycle
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (check) begin
      entries[check_idx] <= state_in;
    end
  end

  assign state_out = entries[recover_idx];

  // Only meaningful when CHECKPOINTS is not a power of two
  check_idx_in_range: assert property (
    @(posedge clock) check |-> (int'(check_idx) < CHECKPOINTS)
  ) else $error("snapshot_store: check_idx %0d out of range", check_idx);

endmodule

//--- tb_rename_unit.sv
// Directed testbench for the rename stage, checked against a reference model.
// Written for RENAME_WIDTH of 2 and CHECKPOINTS of 4.
// The model holds its own map, free queue and checkpoints. It is updated
// once per cycle, after the DUT outputs of that cycle are compared.

`timescale 1ns/1ps

module tb_rename_unit;

  import rename_pkg::*;

  localparam int W = 2;
  localparam int CP = 4;
  localparam int RANDOM_CYCLES = 200;
  // Reset, identity reads, single, group, checkpoint, drain and refill, random
  localparam int TEST_CYCLES = 4 + 8 + 5 + 2 + 8 + (PRF_SIZE / W + 6) + RANDOM_CYCLES;

  logic clock = 1'b0;
  logic reset;
  logic [W-1:0] rename_valid;
  logic [W-1:0] retire_valid;
  arch_idx_t [W-1:0] rs1, rs2, rd;
  phys_idx_t [W-1:0] prs1, prs2, prd, prev_prd, retire_prd;
  logic allocatable, check, recover;
  logic [1:0] check_idx, recover_idx;

  // Reference model state
  phys_idx_t m_map [ARF_SIZE];
  phys_idx_t m_queue [PRF_SIZE];
  int m_head;
  int m_tail;
  phys_idx_t cp_map [CP][ARF_SIZE];
  int cp_head [CP];
  bit cp_valid [CP];

  phys_idx_t got_prd [W];
  phys_idx_t got_prev [W];
  phys_idx_t got_prs1 [W];
  phys_idx_t retire_pool [$];
  int checks_done = 0;
  int error_count = 0;

  rename_unit #(.RENAME_WIDTH(W), .CHECKPOINTS(CP)) dut (.*);

  always #20 clock = ~clock;

  ////////////////////////////////////////////////////////////////////////////
  // Compare tasks and model helpers
  ////////////////////////////////////////////////////////////////////////////

  task automatic compare_phys(input string what, input phys_idx_t got, input phys_idx_t exp);
    checks_done++;
    if (got !== exp) begin
      error_count++;
      $display("FAIL %0t: %s got %0d expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic compare_bit(input string what, input logic got, input logic exp);
    checks_done++;
    if (got !== exp) begin
      error_count++;
      $display("FAIL %0t: %s got %b expected %b", $time, what, got, exp);
    end
  endtask

  function automatic int free_count();
    return m_tail - m_head;
  endfunction

  task automatic reset_model();
    for (int i = 0; i < ARF_SIZE; i++) begin
      m_map[i] = phys_idx_t'(i);
    end
    for (int i = 0; i < PRF_SIZE; i++) begin
      m_queue[i] = phys_idx_t'(i + ARF_SIZE);
    end
    m_head = 0;
    m_tail = FREE_AT_RESET;
    for (int c = 0; c < CP; c++) begin
      cp_valid[c] = 1'b0;
    end
  endtask

  // One cycle: drive, compare the combinational outputs, then step the model
  task automatic apply(input logic [W-1:0] rv, input arch_idx_t [W-1:0] a1,
                       input arch_idx_t [W-1:0] a2, input arch_idx_t [W-1:0] d,
                       input logic chk, input logic [1:0] cidx,
                       input logic rec, input logic [1:0] ridx,
                       input logic [W-1:0] retv, input phys_idx_t [W-1:0] retp);
    phys_idx_t work [ARF_SIZE];
    phys_idx_t saved_map [ARF_SIZE];
    int saved_head;
    int offset;
    @(posedge clock);
    #1;
    rename_valid = rv;
    rs1 = a1;
    rs2 = a2;
    rd = d;
    check = chk;
    check_idx = cidx;
    recover = rec;
    recover_idx = ridx;
    retire_valid = retv;
    retire_prd = retp;
    #10;
    work = m_map;
    offset = 0;
    compare_bit("allocatable", allocatable, free_count() >= W);
    for (int k = 0; k < W; k++) begin
      compare_phys($sformatf("prs1[%0d]", k), prs1[k], work[a1[k]]);
      compare_phys($sformatf("prs2[%0d]", k), prs2[k], work[a2[k]]);
      got_prd[k] = prd[k];
      got_prev[k] = prev_prd[k];
      got_prs1[k] = prs1[k];
      if (rv[k] && !rec) begin
        compare_phys($sformatf("prev_prd[%0d]", k), prev_prd[k], work[d[k]]);
        compare_phys($sformatf("prd[%0d]", k), prd[k], m_queue[phys_idx_t'(m_head + offset)]);
        work[d[k]] = m_queue[phys_idx_t'(m_head + offset)];
        offset++;
      end
    end
    // Recover reads the checkpoint as it stood before this cycle's check
    saved_map = cp_map[ridx];
    saved_head = cp_head[ridx];
    // Checkpoint takes the state from before this cycle's renames
    if (chk) begin
      cp_map[cidx] = m_map;
      cp_head[cidx] = m_head;
      cp_valid[cidx] = 1'b1;
    end
    if (rec) begin
      m_map = saved_map;
      m_head = saved_head;
    end else begin
      m_map = work;
      m_head += offset;
    end
    for (int k = 0; k < W; k++) begin
      if (retv[k]) begin
        m_queue[phys_idx_t'(m_tail)] = retp[k];
        m_tail++;
      end
    end
  endtask

  task automatic rename_cycle(input logic [W-1:0] rv, input int s1a, input int s2a,
                              input int da, input int s1b, input int s2b, input int db);
    apply(rv, {arch_idx_t'(s1b), arch_idx_t'(s1a)}, {arch_idx_t'(s2b), arch_idx_t'(s2a)},
          {arch_idx_t'(db), arch_idx_t'(da)}, 1'b0, 2'd0, 1'b0, 2'd0, '0, '0);
  endtask

  task automatic retire_cycle(input logic [W-1:0] retv, input phys_idx_t p0, input phys_idx_t p1);
    apply('0, '0, '0, '0, 1'b0, 2'd0, 1'b0, 2'd0, retv, {p1, p0});
  endtask

  task automatic state_cycle(input logic chk, input logic [1:0] cidx,
                             input logic rec, input logic [1:0] ridx);
    apply('0, '0, '0, '0, chk, cidx, rec, ridx, '0, '0);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_reset_map();
    compare_bit("allocatable after reset", allocatable, 1'b1);
    for (int i = 0; i < ARF_SIZE; i += 4) begin
      rename_cycle(2'b00, i, i + 1, 0, i + 2, i + 3, 0);
    end
  endtask

  task automatic single_renames();
    for (int i = 0; i < 4; i++) begin
      // Each rename reads the destination of the one before
      rename_cycle(2'b01, i, 0, i + 1, 0, 0, 0);
      compare_phys("prd in free-list order", got_prd[0], phys_idx_t'(ARF_SIZE + i));
    end
    rename_cycle(2'b00, 1, 2, 0, 3, 4, 0);
  endtask

  task automatic group_dependence();
    phys_idx_t slot0_new;
    slot0_new = m_queue[phys_idx_t'(m_head)];
    rename_cycle(2'b11, 1, 2, 5, 5, 3, 6);
    compare_phys("slot 1 source from slot 0", got_prs1[1], slot0_new);
    slot0_new = m_queue[phys_idx_t'(m_head)];
    rename_cycle(2'b11, 0, 0, 7, 0, 0, 7);
    compare_phys("slot 1 prev from slot 0", got_prev[1], slot0_new);
  endtask

  task automatic checkpoint_recover();
    phys_idx_t handed [$];
    state_cycle(1'b1, 2'd2, 1'b0, 2'd0);
    for (int i = 0; i < 3; i++) begin
      handed.push_back(m_queue[phys_idx_t'(m_head)]);
      handed.push_back(m_queue[phys_idx_t'(m_head + 1)]);
      rename_cycle(2'b11, 10, 11, 10 + 2 * i, 12, 13, 11 + 2 * i);
    end
    state_cycle(1'b0, 2'd0, 1'b1, 2'd2);
    for (int i = 0; i < 3; i++) begin
      rename_cycle(2'b11, 10 + 2 * i, 11 + 2 * i, 20, 0, 0, 21);
      compare_phys("slot 0 reallocated", got_prd[0], handed.pop_front());
      compare_phys("slot 1 reallocated", got_prd[1], handed.pop_front());
    end
  endtask

  task automatic exhaust_and_refill();
    phys_idx_t first;
    phys_idx_t second;
    int leftover;
    while (free_count() >= W) begin
      rename_cycle(2'b11, 1, 2, 3, 3, 4, 12);
      retire_pool.push_back(got_prev[0]);
      retire_pool.push_back(got_prev[1]);
    end
    rename_cycle(2'b00, 0, 0, 0, 0, 0, 0);
    compare_bit("allocatable with free list drained", allocatable, 1'b0);
    first = retire_pool.pop_front();
    second = retire_pool.pop_front();
    leftover = free_count();
    retire_cycle(2'b11, first, second);
    repeat (leftover) rename_cycle(2'b01, 0, 0, 9, 0, 0, 0);
    rename_cycle(2'b11, 1, 2, 14, 3, 4, 15);
    compare_phys("first retired reused", got_prd[0], first);
    compare_phys("second retired reused", got_prd[1], second);
  endtask

  task automatic random_mix(input int cycles);
    logic [W-1:0] rv;
    logic [W-1:0] retv;
    logic chk;
    logic rec;
    logic [1:0] cidx;
    logic [1:0] ridx;
    phys_idx_t [W-1:0] retp;
    int nret;
    for (int n = 0; n < cycles; n++) begin
      cidx = 2'($urandom_range(CP - 1));
      ridx = 2'($urandom_range(CP - 1));
      chk = ($urandom_range(7) == 0);
      // Recover only to a checkpoint that keeps the free count in range
      rec = ($urandom_range(9) == 0) && cp_valid[ridx] && (cp_head[ridx] <= m_head)
            && (m_tail - cp_head[ridx] <= PRF_SIZE);
      rv = (rec || free_count() < W) ? '0 : W'($urandom_range(3));
      retv = '0;
      retp = '0;
      nret = 0;
      for (int k = 0; k < W; k++) begin
        if (!rec && retire_pool.size() > 0 && $urandom_range(1) == 1
            && free_count() + nret < PRF_SIZE) begin
          retv[k] = 1'b1;
          retp[k] = retire_pool.pop_front();
          nret++;
        end
      end
      apply(rv, {arch_idx_t'($urandom), arch_idx_t'($urandom)},
            {arch_idx_t'($urandom), arch_idx_t'($urandom)},
            {arch_idx_t'($urandom), arch_idx_t'($urandom)}, chk, cidx, rec, ridx, retv, retp);
      for (int k = 0; k < W; k++) begin
        if (rv[k]) begin
          retire_pool.push_back(got_prev[k]);
        end
      end
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Sequence and watchdog
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    void'($urandom(32'hf21b));
    reset = 1'b1;
    rename_valid = '0;
    retire_valid = '0;
    rs1 = '0;
    rs2 = '0;
    rd = '0;
    retire_prd = '0;
    check = 1'b0;
    check_idx = '0;
    recover = 1'b0;
    recover_idx = '0;
    reset_model();
    repeat (3) @(posedge clock);
    #1;
    reset = 1'b0;
    check_reset_map();
    single_renames();
    group_dependence();
    checkpoint_recover();
    exhaust_and_refill();
    random_mix(RANDOM_CYCLES);
    state_cycle(1'b0, 2'd0, 1'b0, 2'd0);
    $display("Checks: %0d, errors: %0d", checks_done, error_count);
    if (error_count == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

  initial begin
    #(TEST_CYCLES * 2 * 40);
    $display("Watchdog timeout: the tests did not finish in time");
    $display("RESULT: FAIL");
    $finish;
  end

endmodule

//--- verilog.f
rename_pkg.sv
snapshot_store.sv
free_list.sv
map_table.sv
rename_unit.sv
tb_rename_unit.sv
